/* dispatch_stage.sv */
/*
 * Dispatch stage of the back end.
 * Registers one incoming operation per cycle and marks its sources
 * ready from a pending-tag scoreboard, cleared by CDB broadcasts.
 */

`timescale 1ns/1ps

module dispatch_stage (
    input  logic                 clock,
    input  logic                 rst_n,
    input  logic                 disp_valid,
    input  isa_pkg::opcode_e     disp_op,
    input  uarch_pkg::tag_t      disp_dest,
    input  uarch_pkg::tag_t      disp_src1,
    input  isa_pkg::operand2_u   disp_operand2,
    input  logic                 cdb_valid,
    input  uarch_pkg::tag_t      cdb_tag,
    output logic                 alloc_valid,
    output uarch_pkg::rs_entry_t alloc_entry
);
    import isa_pkg::*;
    import uarch_pkg::*;

    logic [NUM_TAGS-1:0] pending_q;        // Tag has a producer in flight
    logic                src1_rdy;
    logic                src2_rdy;
    tag_t                src2_tag;
    rs_entry_t           entry_d;

    //////////////////////////////
    // Readiness lookup
    //////////////////////////////

    always_comb begin
        src2_tag = disp_operand2.src.tag;
        // A broadcast this cycle counts, scoreboard clears only at the edge
        src1_rdy = !pending_q[disp_src1] || (cdb_valid && (cdb_tag == disp_src1));
        src2_rdy = op_uses_imm(disp_op) || !pending_q[src2_tag]
                   || (cdb_valid && (cdb_tag == src2_tag));

        entry_d            = '0;
        entry_d.valid      = 1'b1;
        entry_d.op         = disp_op;
        entry_d.dest       = disp_dest;
        entry_d.src1       = disp_src1;
        entry_d.src1_ready = src1_rdy;
        entry_d.operand2   = disp_operand2;
        entry_d.src2_ready = src2_rdy;
    end

    //////////////////////////////
    // Scoreboard
    //////////////////////////////

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            pending_q <= '0;
        end else begin
            if (cdb_valid)
                pending_q[cdb_tag] <= 1'b0;    // Producer done
            if (disp_valid)
                pending_q[disp_dest] <= 1'b1;  // New producer, wins over clear
        end
    end

    // Pipeline register toward the station
    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n)
            alloc_valid <= 1'b0;
        else
            alloc_valid <= disp_valid;
    end

    always_ff @(posedge clock) begin
        if (disp_valid)
            alloc_entry <= entry_d;
    end

    // Source only reuses a dest tag once its last producer has completed
    a_dest_not_pending: assert property (@(posedge clock) disable iff (!rst_n)
        disp_valid |-> (!pending_q[disp_dest] || (cdb_valid && (cdb_tag == disp_dest))));

endmodule

/* exec_unit.sv */
/*
 * Execution unit of the back end.
 * Stage 1 reads operands from the physical value file and runs the
 * ALU, stage 2 registers the result onto the CDB. The value file
 * is written from the CDB at the end of the broadcast cycle.
 */

`timescale 1ns/1ps

module exec_unit (
    input  logic                 clock,
    input  logic                 rst_n,
    input  logic                 ex_valid,
    input  uarch_pkg::rs_entry_t ex_entry,
    output logic                 cdb_valid,
    output uarch_pkg::tag_t      cdb_tag,
    output uarch_pkg::value_t    cdb_value
);
    import isa_pkg::*;
    import uarch_pkg::*;

    value_t vfile_q [NUM_TAGS];            // Physical value file
    value_t opnd_a;
    value_t opnd_b;
    value_t result;
    tag_t   src2_tag;

    //////////////////////////////
    // Stage 1, read and compute
    //////////////////////////////

    always_comb begin
        src2_tag = ex_entry.operand2.src.tag;
        opnd_a   = vfile_q[ex_entry.src1];
        if (op_uses_imm(ex_entry.op))
            opnd_b = imm_sext(ex_entry.operand2.imm);   // Immediate view
        else
            opnd_b = vfile_q[src2_tag];                 // Register view
        result = alu_eval(ex_entry.op, opnd_a, opnd_b);
    end

    //////////////////////////////
    // Stage 2, CDB register
    //////////////////////////////

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n)
            cdb_valid <= 1'b0;
        else
            cdb_valid <= ex_valid;
    end

    always_ff @(posedge clock) begin
        if (ex_valid) begin
            cdb_tag   <= ex_entry.dest;
            cdb_value <= result;
        end
    end

    // File update trails the broadcast by one edge
    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < NUM_TAGS; i++) begin
                vfile_q[i] <= '0;
            end
        end else if (cdb_valid) begin
            vfile_q[cdb_tag] <= cdb_value;
        end
    end

    // Consumers are woken by the CDB, so a source never equals the tag in flight
    a_no_raw_hazard: assert property (@(posedge clock) disable iff (!rst_n)
        (ex_valid && cdb_valid) |-> (ex_entry.src1 != cdb_tag
            && (op_uses_imm(ex_entry.op) || src2_tag != cdb_tag)));

endmodule

/* filelist.f */
isa_pkg.sv
uarch_pkg.sv
dispatch_stage.sv
reservation_station.sv
issue_select.sv
exec_unit.sv
ooo_core_top.sv
tb_checker.sv
tb_top.sv

/* isa_pkg.sv */
/*
 * Instruction set of the small core back end.
 * Opcodes, the second operand word and the rules for evaluating an
 * operation. Shared by dispatch, the execution unit and the checker.
 */

package isa_pkg;

    localparam int XLEN  = 32;             // Architectural value width
    localparam int IMM_W = 16;             // Immediate field width
    localparam int REG_W = 5;              // Source tag field width

    typedef enum logic [2:0] {
        OP_ADD  = 3'd0,
        OP_SUB  = 3'd1,
        OP_XOR  = 3'd2,
        OP_AND  = 3'd3,
        OP_ADDI = 3'd4,                    // src1 + sign-extended imm
        OP_XORI = 3'd5                     // src1 ^ sign-extended imm
    } opcode_e;

    // Tag view of operand 2, upper bits unused
    typedef struct packed {
        logic [IMM_W-REG_W-1:0] pad;
        logic [REG_W-1:0]       tag;
    } operand2_src_t;

    // Same word read as a register tag or as an immediate
    typedef union packed {
        operand2_src_t    src;
        logic [IMM_W-1:0] imm;
    } operand2_u;

    function automatic logic op_uses_imm(opcode_e op);
        return (op == OP_ADDI) || (op == OP_XORI);
    endfunction

    function automatic logic [XLEN-1:0] imm_sext(logic [IMM_W-1:0] imm);
        return {{(XLEN-IMM_W){imm[IMM_W-1]}}, imm};
    endfunction

    function automatic logic [XLEN-1:0] alu_eval(opcode_e op, logic [XLEN-1:0] a,
                                                 logic [XLEN-1:0] b);
        case (op)
            OP_ADD, OP_ADDI: return a + b;
            OP_SUB:          return a - b;
            OP_XOR, OP_XORI: return a ^ b;
            OP_AND:          return a & b;
            default:         return '0;   // Unused encodings
        endcase
    endfunction

endpackage

/* issue_select.sv */
/*
 * Oldest-first issue selector.
 * Keeps an age matrix over the station slots, updated on each
 * allocation, and grants the ready entry with no older ready entry.
 */

`timescale 1ns/1ps

module issue_select #(
    parameter int RS_DEPTH = 8
) (
    input  logic                                clock,
    input  logic                                rst_n,
    input  uarch_pkg::rs_entry_t [RS_DEPTH-1:0] entries,
    input  logic                                alloc_valid,
    input  logic [$clog2(RS_DEPTH)-1:0]         alloc_slot,
    output logic                                issue_valid,
    output logic [$clog2(RS_DEPTH)-1:0]         issue_idx
);
    localparam int IDX_W = $clog2(RS_DEPTH);

    // Row i holds a 1 for every slot older than slot i
    logic [RS_DEPTH-1:0][RS_DEPTH-1:0] older_q;
    logic [RS_DEPTH-1:0]               valid_vec;
    logic [RS_DEPTH-1:0]               ready_vec;
    logic [RS_DEPTH-1:0]               grant;

    always_comb begin
        issue_idx = '0;
        for (int i = 0; i < RS_DEPTH; i++) begin
            valid_vec[i] = entries[i].valid;
            ready_vec[i] = entries[i].valid && entries[i].src1_ready && entries[i].src2_ready;
        end
        for (int i = 0; i < RS_DEPTH; i++) begin
            grant[i] = ready_vec[i] && !(|(older_q[i] & ready_vec));  // No older ready
            if (grant[i])
                issue_idx = IDX_W'(i);
        end
        issue_valid = |grant;
    end

    //////////////////////////////
    // Age matrix update
    //////////////////////////////

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            older_q <= '0;
        end else if (alloc_valid) begin
            for (int i = 0; i < RS_DEPTH; i++) begin
                if (i == int'(alloc_slot))
                    older_q[i] <= valid_vec & ~(RS_DEPTH'(1) << alloc_slot);  // All live are older
                else
                    older_q[i][alloc_slot] <= 1'b0;  // Newcomer younger than everyone
            end
        end
    end

    a_one_grant: assert property (@(posedge clock) disable iff (!rst_n)
        $onehot0(grant));

    // Matrix stays acyclic, so some ready entry is always the oldest
    a_ready_granted: assert property (@(posedge clock) disable iff (!rst_n)
        (|ready_vec) |-> issue_valid);

endmodule

/* ooo_core_top.sv */
/*
 * Top level of the out-of-order back end.
 * Chains dispatch, reservation station, issue selector and execution
 * unit, and sets the station depth for the station and the selector.
 */

`timescale 1ns/1ps

module ooo_core_top #(
    parameter int RS_DEPTH = 8
) (
    input  logic               clock,
    input  logic               rst_n,
    input  logic               disp_valid,
    input  isa_pkg::opcode_e   disp_op,
    input  uarch_pkg::tag_t    disp_dest,
    input  uarch_pkg::tag_t    disp_src1,
    input  isa_pkg::operand2_u disp_operand2,
    output logic               cdb_valid,
    output uarch_pkg::tag_t    cdb_tag,
    output uarch_pkg::value_t  cdb_value,
    output logic               credit_return
);
    import uarch_pkg::*;

    localparam int IDX_W = $clog2(RS_DEPTH);

    // Dispatch to station
    logic                      alloc_valid;
    rs_entry_t                 alloc_entry;
    // Station to selector and back
    rs_entry_t [RS_DEPTH-1:0]  entries;
    logic [IDX_W-1:0]          alloc_slot;
    logic                      issue_valid;
    logic [IDX_W-1:0]          issue_idx;
    // Station to execution
    logic                      ex_valid;
    rs_entry_t                 ex_entry;

    dispatch_stage i_dispatch_stage (
        .clock, .rst_n, .disp_valid, .disp_op, .disp_dest, .disp_src1, .disp_operand2,
        .cdb_valid, .cdb_tag, .alloc_valid, .alloc_entry
    );

    reservation_station #(.RS_DEPTH(RS_DEPTH)) i_reservation_station (
        .clock, .rst_n, .alloc_valid, .alloc_entry, .cdb_valid, .cdb_tag,
        .issue_valid, .issue_idx, .entries, .alloc_slot, .ex_valid, .ex_entry,
        .credit_return
    );

    issue_select #(.RS_DEPTH(RS_DEPTH)) i_issue_select (
        .clock, .rst_n, .entries, .alloc_valid, .alloc_slot, .issue_valid, .issue_idx
    );

    exec_unit i_exec_unit (
        .clock, .rst_n, .ex_valid, .ex_entry, .cdb_valid, .cdb_tag, .cdb_value
    );

endmodule

/* reservation_station.sv */
/*
 * Reservation station of the back end.
 * Holds RS_DEPTH waiting operations, fills the lowest free slot,
 * wakes operands on CDB tag match and hands the issued entry to
 * the execution unit while returning one credit per freed slot.
 */

`timescale 1ns/1ps

module reservation_station #(
    parameter int RS_DEPTH = 8
) (
    input  logic                                  clock,
    input  logic                                  rst_n,
    input  logic                                  alloc_valid,
    input  uarch_pkg::rs_entry_t                  alloc_entry,
    input  logic                                  cdb_valid,
    input  uarch_pkg::tag_t                       cdb_tag,
    input  logic                                  issue_valid,
    input  logic [$clog2(RS_DEPTH)-1:0]           issue_idx,
    output uarch_pkg::rs_entry_t [RS_DEPTH-1:0]   entries,
    output logic [$clog2(RS_DEPTH)-1:0]           alloc_slot,
    output logic                                  ex_valid,
    output uarch_pkg::rs_entry_t                  ex_entry,
    output logic                                  credit_return
);
    import isa_pkg::*;
    import uarch_pkg::*;

    localparam int IDX_W = $clog2(RS_DEPTH);

    rs_entry_t [RS_DEPTH-1:0] rs_q;         // Current entries
    rs_entry_t [RS_DEPTH-1:0] rs_d;         // Next-state entries
    logic      [RS_DEPTH-1:0] valid_vec;
    logic      [RS_DEPTH-1:0] free_vec;     // Free now or freed by issue

    //////////////////////////////
    // Free slot search
    //////////////////////////////

    always_comb begin
        for (int i = 0; i < RS_DEPTH; i++) begin
            valid_vec[i] = rs_q[i].valid;
        end
        free_vec = ~valid_vec;
        if (issue_valid)
            free_vec[issue_idx] = 1'b1;     // Issuing slot reusable this edge

        // Walk down so the lowest free index wins
        alloc_slot = '0;
        for (int i = RS_DEPTH - 1; i >= 0; i--) begin
            if (free_vec[i])
                alloc_slot = IDX_W'(i);
        end
    end

    //////////////////////////////
    // Next state
    //////////////////////////////

    always_comb begin
        rs_d = rs_q;

        if (issue_valid)
            rs_d[issue_idx].valid = 1'b0;   // Clear issued entry

        if (alloc_valid && |free_vec)
            rs_d[alloc_slot] = alloc_entry;

        // CDB wakeup, also covers the entry being written now
        for (int i = 0; i < RS_DEPTH; i++) begin
            if (rs_d[i].valid && cdb_valid) begin
                if (rs_d[i].src1 == cdb_tag)
                    rs_d[i].src1_ready = 1'b1;
                if (!op_uses_imm(rs_d[i].op) && (rs_d[i].operand2.src.tag == cdb_tag))
                    rs_d[i].src2_ready = 1'b1;  // Tag view only for register ops
            end
        end
    end

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n)
            rs_q <= '0;
        else
            rs_q <= rs_d;
    end

    assign entries = rs_q;

    //////////////////////////////
    // Issue register and credits
    //////////////////////////////

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            ex_valid      <= 1'b0;
            credit_return <= 1'b0;
        end else begin
            ex_valid      <= issue_valid;
            credit_return <= issue_valid;   // One credit per freed slot
        end
    end

    always_ff @(posedge clock) begin
        if (issue_valid)
            ex_entry <= rs_q[issue_idx];
    end

    // Credit flow keeps the source from overfilling the station
    a_no_alloc_when_full: assert property (@(posedge clock) disable iff (!rst_n)
        alloc_valid |-> (!(&valid_vec) || issue_valid));

    // Selector only grants what the station holds as ready
    a_issue_is_ready: assert property (@(posedge clock) disable iff (!rst_n)
        issue_valid |-> (rs_q[issue_idx].valid && rs_q[issue_idx].src1_ready
                         && rs_q[issue_idx].src2_ready));

endmodule

/* run_sim.sh */
#!/bin/sh
# Build the back end and its testbench with Verilator, run it, check the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert -j 0 --top-module tb_top -f filelist.f -o tb_sim \
    && ./obj_dir/tb_sim > sim.log 2>&1
cat sim.log 2>/dev/null
grep -qx "All checks passed" sim.log && echo "Simulation passed" && exit 0 \
    || { echo "Simulation failed"; exit 1; }

/* tb_checker.sv */
/*
 * Checker of the back end testbench.
 * Keeps a program-order value model per tag, compares every CDB
 * result against it and watches credits, ordering and reset quiet.
 */

`timescale 1ns/1ps

module tb_checker #(
    parameter int RS_DEPTH = 8
) (
    input  logic               clock,
    input  logic               rst_n,
    input  logic               disp_valid,
    input  isa_pkg::opcode_e   disp_op,
    input  uarch_pkg::tag_t    disp_dest,
    input  uarch_pkg::tag_t    disp_src1,
    input  isa_pkg::operand2_u disp_operand2,
    input  logic               cdb_valid,
    input  uarch_pkg::tag_t    cdb_tag,
    input  uarch_pkg::value_t  cdb_value,
    input  logic               credit_return,
    input  logic               order_check,
    input  logic               final_check,
    output logic               final_done,
    output int                 data_errors,
    output int                 protocol_errors
);
    import isa_pkg::*;
    import uarch_pkg::*;

    value_t model_q  [NUM_TAGS];           // Program-order value of each tag
    value_t expect_q [NUM_TAGS];           // Result owed by the producer in flight
    logic   inflight [NUM_TAGS];
    tag_t   order_q [$];                   // Dispatch order, first phase only
    int     credits;
    logic   first_cycle = 1'b0;
    int     data_cnt    = 0;
    int     proto_cnt   = 0;

    assign data_errors     = data_cnt;
    assign protocol_errors = proto_cnt;

    function automatic logic is_imm_op(opcode_e op);
        return (op == OP_ADDI) || (op == OP_XORI);
    endfunction

    function automatic value_t reference_alu(opcode_e op, value_t a, value_t b);
        case (op)
            OP_ADD, OP_ADDI: return a + b;
            OP_SUB:          return a - b;
            OP_XOR, OP_XORI: return a ^ b;
            default:         return a & b;
        endcase
    endfunction

    //////////////////////////////
    // Check tasks
    //////////////////////////////

    task automatic clear_model();
        for (int t = 0; t < NUM_TAGS; t++) begin
            model_q[t]  = '0;               // Value file starts at zero
            expect_q[t] = '0;
            inflight[t] = 1'b0;
        end
        order_q.delete();
        credits = RS_DEPTH;
    endtask

    task automatic check_outputs_low(input string phase);
        if (cdb_valid !== 1'b0 || credit_return !== 1'b0) begin
            $display("cdb_valid or credit_return was high during %s", phase);
            proto_cnt++;
        end
    endtask

    task automatic record_dispatch();
        value_t b;
        if (is_imm_op(disp_op))
            b = {{16{disp_operand2.imm[15]}}, disp_operand2.imm};
        else
            b = model_q[disp_operand2.src.tag];
        expect_q[disp_dest] = reference_alu(disp_op, model_q[disp_src1], b);
        model_q[disp_dest]  = expect_q[disp_dest];
        inflight[disp_dest] = 1'b1;
        if (order_check)
            order_q.push_back(disp_dest);
    endtask

    task automatic check_completion();
        tag_t oldest;
        if (!inflight[cdb_tag]) begin
            $display("Completion of tag %0d that has no operation in flight", cdb_tag);
            proto_cnt++;
        end else if (cdb_value !== expect_q[cdb_tag]) begin
            $display("** Error [cdb_value] tag %0d expected %h actual %h",
                     cdb_tag, expect_q[cdb_tag], cdb_value);
            data_cnt++;
        end
        inflight[cdb_tag] = 1'b0;
        if (order_q.size() > 0) begin
            oldest = order_q.pop_front();
            if (oldest != cdb_tag) begin
                $display("** Error [completion_order] expected tag %0d actual tag %0d",
                         oldest, cdb_tag);
                data_cnt++;
            end
        end
    endtask

    task automatic report_leftovers();
        for (int t = 0; t < NUM_TAGS; t++) begin
            if (inflight[t]) begin
                $display("Tag %0d was dispatched but never completed", t);
                proto_cnt++;
            end
        end
        if (credits != RS_DEPTH) begin
            $display("** Error [credit_drain] expected %0d actual %0d", RS_DEPTH, credits);
            proto_cnt++;
        end
    endtask

    always @(posedge clock) begin
        if (!rst_n) begin
            clear_model();
            check_outputs_low("reset");
            first_cycle = 1'b1;
            final_done <= 1'b0;
        end else begin
            if (first_cycle)
                check_outputs_low("the first cycle after reset");
            first_cycle = 1'b0;
            if (cdb_valid)
                check_completion();
            if (disp_valid)
                record_dispatch();
            // Source may hold between zero and a full station of credits
            credits = credits + (credit_return ? 1 : 0) - (disp_valid ? 1 : 0);
            if (credits < 0 || credits > RS_DEPTH) begin
                $display("Source credits out of range, %0d held", credits);
                proto_cnt++;
            end
            if (final_check && !final_done) begin
                report_leftovers();
                final_done <= 1'b1;
            end
        end
    end

endmodule

/* tb_top.sv */
/*
 * Testbench top for the out-of-order back end.
 * Runs a seeded random operation stream under credit flow control,
 * first independent immediates, then dependent mixed operations,
 * and prints a summary once the checker has finished.
 */

`timescale 1ns/1ps

module tb_top;
    import isa_pkg::*;
    import uarch_pkg::*;

    localparam int RS_DEPTH      = 8;
    localparam int SEED          = 61;
    localparam int NUM_OPS       = 400;
    localparam int INDEP_OPS     = 100;    // First phase, all ready at dispatch
    localparam int SEND_TIMEOUT  = 200;    // Idle cycles without credit or free tag
    localparam int DRAIN_TIMEOUT = 1000;
    localparam int DONE_TIMEOUT  = 20;

    logic      clock;
    logic      rst_n;
    logic      disp_valid;
    opcode_e   disp_op;
    tag_t      disp_dest;
    tag_t      disp_src1;
    operand2_u disp_operand2;
    logic      cdb_valid;
    tag_t      cdb_tag;
    value_t    cdb_value;
    logic      credit_return;
    logic      order_check;
    logic      final_check;
    logic      final_done;
    int        data_errors;
    int        protocol_errors;

    // Source side bookkeeping
    int                  credits;
    logic [NUM_TAGS-1:0] busy;              // Tag has a producer in flight
    int                  readers [NUM_TAGS]; // In-flight operations reading the tag
    tag_t                read_a  [NUM_TAGS]; // Sources of the producer of each tag
    tag_t                read_b  [NUM_TAGS];
    logic                has_b   [NUM_TAGS];
    int                  outstanding;
    int                  timeouts;

    initial begin
        clock = 1'b0;
        forever #4 clock = ~clock;
    end

    ooo_core_top #(.RS_DEPTH(RS_DEPTH)) i_ooo_core_top (
        .clock, .rst_n, .disp_valid, .disp_op, .disp_dest, .disp_src1, .disp_operand2,
        .cdb_valid, .cdb_tag, .cdb_value, .credit_return
    );

    tb_checker #(.RS_DEPTH(RS_DEPTH)) i_tb_checker (
        .clock, .rst_n, .disp_valid, .disp_op, .disp_dest, .disp_src1, .disp_operand2,
        .cdb_valid, .cdb_tag, .cdb_value, .credit_return, .order_check, .final_check,
        .final_done, .data_errors, .protocol_errors
    );

    //////////////////////////////
    // Cycle step and stimulus
    //////////////////////////////

    // Advance one edge and account for credits and completions seen there
    task automatic next_cycle();
        @(posedge clock);
        disp_valid <= 1'b0;                 // Idle unless a send follows
        if (credit_return)
            credits++;
        if (cdb_valid) begin
            busy[cdb_tag] = 1'b0;
            readers[read_a[cdb_tag]]--;
            if (has_b[cdb_tag])
                readers[read_b[cdb_tag]]--;
            outstanding--;
        end
    endtask

    task automatic try_send(input logic dependent, output logic sent_one);
        int        free_tags [$];
        int        settled [$];
        int        dest;
        int        src1;
        int        src2;
        opcode_e   op;
        operand2_u opnd2;
        sent_one = 1'b0;
        for (int t = 0; t < NUM_TAGS; t++) begin
            if (!busy[t] && readers[t] == 0)
                free_tags.push_back(t);     // No producer and no waiting reader
            if (!busy[t])
                settled.push_back(t);
        end
        if (credits == 0 || free_tags.size() == 0)
            return;
        if (dependent && $urandom_range(0, 3) == 0)
            return;                         // Random bubble
        dest = free_tags[$urandom_range(0, free_tags.size() - 1)];
        if (dependent) begin
            src1 = int'($urandom_range(0, NUM_TAGS - 1));
            src2 = int'($urandom_range(0, NUM_TAGS - 1));
            op   = opcode_e'(3'($urandom_range(0, 5)));
        end else begin
            src1 = settled[$urandom_range(0, settled.size() - 1)];
            src2 = 0;
            op   = ($urandom_range(0, 1) == 0) ? OP_ADDI : OP_XORI;
        end
        opnd2.imm = 16'($urandom);          // Pad bits stay random in the tag view
        if (!op_uses_imm(op))
            opnd2.src.tag = tag_t'(src2);
        disp_valid    <= 1'b1;
        disp_op       <= op;
        disp_dest     <= tag_t'(dest);
        disp_src1     <= tag_t'(src1);
        disp_operand2 <= opnd2;
        credits--;
        busy[dest]   = 1'b1;
        read_a[dest] = tag_t'(src1);
        read_b[dest] = tag_t'(src2);
        has_b[dest]  = !op_uses_imm(op);
        readers[src1]++;
        if (!op_uses_imm(op))
            readers[src2]++;
        outstanding++;
        sent_one = 1'b1;
    endtask

    task automatic run_phase(input logic dependent, input int count);
        int   n;
        int   idle;
        logic sent_one;
        n    = 0;
        idle = 0;
        while (n < count) begin
            next_cycle();
            try_send(dependent, sent_one);
            if (sent_one) begin
                n++;
                idle = 0;
            end else if (++idle > SEND_TIMEOUT) begin
                $display("Timeout: no credit or free tag for %0d cycles", SEND_TIMEOUT);
                timeouts++;
                return;
            end
        end
    endtask

    // Wait until every operation completed and all credits came back
    task automatic drain();
        int waited;
        waited = 0;
        while (outstanding != 0 || credits != RS_DEPTH) begin
            next_cycle();
            if (++waited > DRAIN_TIMEOUT) begin
                $display("Timeout: %0d operations still in flight", outstanding);
                timeouts++;
                return;
            end
        end
    endtask

    task automatic collect_final();
        int waited;
        waited = 0;
        final_check <= 1'b1;
        while (!final_done) begin
            next_cycle();
            if (++waited > DONE_TIMEOUT) begin
                $display("Timeout: checker did not finish its final checks");
                timeouts++;
                return;
            end
        end
    endtask

    //////////////////////////////
    // Main sequence
    //////////////////////////////

    initial begin
        rst_n         <= 1'b0;
        disp_valid    <= 1'b0;
        disp_op       <= OP_ADD;
        disp_dest     <= '0;
        disp_src1     <= '0;
        disp_operand2 <= '0;
        order_check   <= 1'b0;
        final_check   <= 1'b0;
        credits     = RS_DEPTH;
        busy        = '0;
        outstanding = 0;
        timeouts    = 0;
        for (int t = 0; t < NUM_TAGS; t++) begin
            readers[t] = 0;
            has_b[t]   = 1'b0;
        end
        void'($urandom(SEED));
        repeat (4) @(posedge clock);
        rst_n       <= 1'b1;
        order_check <= 1'b1;                // Completions must follow dispatch order
        run_phase(1'b0, INDEP_OPS);
        if (timeouts == 0)
            drain();
        order_check <= 1'b0;
        if (timeouts == 0)
            run_phase(1'b1, NUM_OPS - INDEP_OPS);
        if (timeouts == 0)
            drain();
        if (timeouts == 0)
            collect_final();
        $display("Summary: %0d data errors, %0d protocol errors, %0d timeouts",
                 data_errors, protocol_errors, timeouts);
        if (data_errors + protocol_errors + timeouts == 0)
            $display("All checks passed");
        else
            $display("Checks failed");
        $finish;
    end

endmodule

/* uarch_pkg.sv */
/*
 * Microarchitecture definitions of the back end.
 * Physical tag and value widths, value file size and the
 * reservation-station entry layout passed between the stages.
 */

package uarch_pkg;

    //////////////////////////////
    // Widths and sizes
    //////////////////////////////

    localparam int TAG_W    = isa_pkg::REG_W;   // Physical tag bits
    localparam int NUM_TAGS = 1 << TAG_W;       // Value file words
    localparam int VALUE_W  = isa_pkg::XLEN;    // Data path width

    typedef logic [TAG_W-1:0]   tag_t;
    typedef logic [VALUE_W-1:0] value_t;

    //////////////////////////////
    // Station entry
    //////////////////////////////

    // One waiting operation with its operand readiness
    typedef struct packed {
        logic               valid;              // Slot holds an operation
        isa_pkg::opcode_e   op;
        tag_t               dest;               // Result tag broadcast on CDB
        tag_t               src1;
        logic               src1_ready;
        isa_pkg::operand2_u operand2;           // Tag or immediate by opcode
        logic               src2_ready;         // Set at once for immediates
    } rs_entry_t;

endpackage
